/* hw/neuron_defs.svh */
`ifndef NEURON_DEFS_SVH
`define NEURON_DEFS_SVH

// Activations per input vector.
`define NEURON_INPUTS 30

// Two activations travel in every beat.
`define NEURON_BEATS 15

// Weight sets for the two lanes.
// Word k of a set sits at bits [32*k+31:32*k], so the last word listed is beat 0.
// Even lane holds weights 0, 2 ... 28.
`define NEURON_WEIGHTS_EVEN { \
	32'hBE030EDC, 32'h3D1CDEA1, 32'h3EC57A28, 32'h3DB7171C, 32'h3FAB7AB7, \
	32'h3F279B8F, 32'h3F1D051F, 32'h3EF3D9B3, 32'h3F73EEFE, 32'h3E4AC912, \
	32'h3E01932E, 32'h3E8658FE, 32'h3EBFA529, 32'hBEA96775, 32'h3ED4EB94  \
}

// Odd lane holds weights 1, 3 ... 29.
`define NEURON_WEIGHTS_ODD { \
	32'hBE8C4201, 32'h3EDCEBB0, 32'h3F45CE2C, 32'h3E80B722, 32'h3F02C632, \
	32'h3F38D8C6, 32'h3EC97007, 32'h3CF298B7, 32'h3F4F3841, 32'h3DEABB07, \
	32'h3EE10F56, 32'hBF0C7B2B, 32'h3ED8CD75, 32'hBF04316F, 32'hBD08B5E1  \
}

// Bias added after the two lane sums are joined.
`define NEURON_BIAS 32'h3EC0B9A7

`endif

/* hw/fpPkg.sv */
package fpPkg;

	typedef logic [7:0] expT;
	typedef logic [22:0] fracT;

	// Significand with the hidden bit restored.
	typedef logic [23:0] sigT;

	// IEEE-754 single precision word.
	typedef struct packed
	{
		logic sign;
		expT exp;
		fracT frac;
	} float32T;

	localparam int EXP_BIAS = 127;

	// Saturation value on exponent overflow.
	localparam float32T FLOAT_MAX_POS = '{sign: 1'b0, exp: 8'hFE, frac: 23'h7FFFFF};

endpackage

/* hw/neuronPkg.sv */
package neuronPkg;

	// Beat position inside one input vector.
	typedef logic [3:0] beatIdxT;

	// Occupancy of the partial sum slot in front of the output register.
	typedef enum logic
	{
		EMPTY = 1'b0,
		FULL = 1'b1
	} joinStateT;

endpackage

/* hw/fpMul.sv */
`timescale 1ns/10ps

module fpMul (
	input  fpPkg::float32T a,
	input  fpPkg::float32T b,
	output fpPkg::float32T y
);

	fpPkg::sigT sigA;
	fpPkg::sigT sigB;
	logic [47:0] prod;
	logic [9:0] expRaw;
	fpPkg::fracT fracOut;
	logic resSign;

	assign sigA = {1'b1, a.frac};
	assign sigB = {1'b1, b.frac};
	assign prod = sigA * sigB;
	assign resSign = a.sign ^ b.sign;

	// Product of two 1.x significands lies in [1, 4), so one place of normalisation.
	assign fracOut = prod[47] ? prod[46:24] : prod[45:23];

	// Ten bits hold the range -127 .. 384 as two's complement.
	assign expRaw = {2'b00, a.exp} + {2'b00, b.exp} + {9'd0, prod[47]}
		- 10'(fpPkg::EXP_BIAS);

	always_comb
	begin
		if (a.exp == 8'd0 || b.exp == 8'd0)
			y = '0;
		else if (expRaw[9] || expRaw == 10'd0)
			y = '{sign: resSign, exp: 8'd0, frac: 23'd0};
		else if (expRaw >= 10'd255)
			y = '{sign: resSign, exp: fpPkg::FLOAT_MAX_POS.exp,
				frac: fpPkg::FLOAT_MAX_POS.frac};
		else
			y = '{sign: resSign, exp: expRaw[7:0], frac: fracOut};
	end

endmodule

/* hw/fpAdd.sv */
`timescale 1ns/10ps

module fpAdd (
	input  fpPkg::float32T a,
	input  fpPkg::float32T b,
	output fpPkg::float32T y
);

	fpPkg::float32T big;
	fpPkg::float32T lesser;
	fpPkg::sigT sigBig;
	fpPkg::sigT sigSmall;
	fpPkg::sigT sigAligned;
	fpPkg::expT shift;
	logic effSub;
	logic [24:0] sigSum;
	logic [4:0] lz;
	logic [23:0] sigNorm;
	logic [8:0] expInc;

	// Counts zeros above the leading one.
	function automatic logic [4:0] leadZeros(input logic [23:0] v);
		logic [4:0] count;
		logic done;
		count = 5'd0;
		done = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (v[i])
				done = 1'b1;
			else if (!done)
				count = count + 5'd1;
		end
		return count;
	endfunction

	// Larger magnitude first. Ties keep a on top.
	assign big = ({a.exp, a.frac} >= {b.exp, b.frac}) ? a : b;
	assign lesser = ({a.exp, a.frac} >= {b.exp, b.frac}) ? b : a;

	// Subnormals count as zero.
	assign sigBig = (big.exp == 8'd0) ? 24'd0 : {1'b1, big.frac};
	assign sigSmall = (lesser.exp == 8'd0) ? 24'd0 : {1'b1, lesser.frac};

	assign shift = big.exp - lesser.exp;
	assign sigAligned = sigSmall >> shift;

	assign effSub = a.sign ^ b.sign;
	assign sigSum = effSub ? {1'b0, sigBig} - {1'b0, sigAligned}
		: {1'b0, sigBig} + {1'b0, sigAligned};

	assign expInc = {1'b0, big.exp} + 9'd1;
	assign lz = leadZeros(sigSum[23:0]);
	assign sigNorm = sigSum[23:0] << lz;

	always_comb
	begin
		y = '0;
		if (sigSum[24])
		begin
			// Carry out of the add, shift right by one.
			y.sign = big.sign;
			if (expInc >= 9'd255)
			begin
				y.exp = fpPkg::FLOAT_MAX_POS.exp;
				y.frac = fpPkg::FLOAT_MAX_POS.frac;
			end
			else
			begin
				y.exp = expInc[7:0];
				y.frac = sigSum[23:1];
			end
		end
		else if (sigSum != 25'd0)
		begin
			y.sign = big.sign;
			if (big.exp > {3'b000, lz})
			begin
				y.exp = big.exp - {3'b000, lz};
				y.frac = sigNorm[22:0];
			end
		end
	end

endmodule

/* hw/macLane.sv */
`timescale 1ns/10ps
`include "neuron_defs.svh"

module macLane #(
	parameter logic [`NEURON_BEATS*32-1:0] WEIGHTS = '0
)(
	input  logic clk,
	input  logic arstN,
	input  logic accEn,
	input  logic first,
	input  neuronPkg::beatIdxT beatIdx,
	input  fpPkg::float32T act,
	output fpPkg::float32T laneSum
);

	fpPkg::float32T weight;
	fpPkg::float32T product;
	fpPkg::float32T sum;
	fpPkg::float32T acc;

	// Weight for this beat.
	assign weight = WEIGHTS[beatIdx*32 +: 32];

	fpMul mul (
		.a(act),
		.b(weight),
		.y(product)
	);

	fpAdd add (
		.a(acc),
		.b(product),
		.y(sum)
	);

	// Beat 0 restarts the sum.
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			acc <= '0;
		else if (accEn)
			acc <= first ? product : sum;
	end

	assign laneSum = acc;

	beatInRange: assert property (@(posedge clk) disable iff (!arstN)
		accEn |-> beatIdx < `NEURON_BEATS);

endmodule

/* hw/nodeCombine.sv */
`timescale 1ns/10ps
`include "neuron_defs.svh"

module nodeCombine #(
	parameter fpPkg::float32T BIAS = '0
)(
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	output logic accEn,
	output logic first,
	output neuronPkg::beatIdxT beatIdx,
	input  fpPkg::float32T laneSum0,
	input  fpPkg::float32T laneSum1,
	output logic outValid,
	input  logic outReady,
	output fpPkg::float32T outData
);

	localparam neuronPkg::beatIdxT LAST_BEAT = neuronPkg::beatIdxT'(`NEURON_BEATS - 1);

	neuronPkg::beatIdxT beatCnt;
	logic vecDone;
	neuronPkg::joinStateT slotState;
	logic slotAdvance;
	fpPkg::float32T partial;
	fpPkg::float32T joinSum;
	fpPkg::float32T biasSum;

	// Slot moves on when the output register is empty or being read.
	assign slotAdvance = (slotState == neuronPkg::FULL) && (!outValid || outReady);

	// Hold the last beat while a stuck slot could still be overwritten.
	assign inReady = !((beatCnt == LAST_BEAT) && (slotState == neuronPkg::FULL)
		&& !slotAdvance);

	assign accEn = inValid && inReady;
	assign first = (beatCnt == '0);
	assign beatIdx = beatCnt;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			beatCnt <= '0;
			vecDone <= 1'b0;
		end
		else
		begin
			vecDone <= accEn && (beatCnt == LAST_BEAT);
			if (accEn)
				beatCnt <= (beatCnt == LAST_BEAT) ? '0 : beatCnt + 1'b1;
		end
	end

	fpAdd joinAdd (
		.a(laneSum0),
		.b(laneSum1),
		.y(joinSum)
	);

	// Lane registers are read here one edge after the last beat.
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			slotState <= neuronPkg::EMPTY;
		else if (vecDone)
			slotState <= neuronPkg::FULL;
		else if (slotAdvance)
			slotState <= neuronPkg::EMPTY;
	end

	always_ff @(posedge clk)
	begin
		if (vecDone)
			partial <= joinSum;
	end

	fpAdd biasAdd (
		.a(partial),
		.b(BIAS),
		.y(biasSum)
	);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (slotAdvance)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// ReLU.
	always_ff @(posedge clk)
	begin
		if (slotAdvance)
			outData <= biasSum.sign ? '0 : biasSum;
	end

	reluNonNeg: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !outData.sign);

	outHold: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outData));

endmodule

/* hw/neuronNode.sv */
`timescale 1ns/10ps
`include "neuron_defs.svh"

module neuronNode (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	input  fpPkg::float32T actEven,
	input  fpPkg::float32T actOdd,
	output logic outValid,
	input  logic outReady,
	output fpPkg::float32T outData
);

	logic accEn;
	logic first;
	neuronPkg::beatIdxT beatIdx;
	fpPkg::float32T laneSum0;
	fpPkg::float32T laneSum1;

	// Even activation indices.
	macLane #(
		.WEIGHTS(`NEURON_WEIGHTS_EVEN)
	) lane0 (
		.clk(clk),
		.arstN(arstN),
		.accEn(accEn),
		.first(first),
		.beatIdx(beatIdx),
		.act(actEven),
		.laneSum(laneSum0)
	);

	// Odd activation indices.
	macLane #(
		.WEIGHTS(`NEURON_WEIGHTS_ODD)
	) lane1 (
		.clk(clk),
		.arstN(arstN),
		.accEn(accEn),
		.first(first),
		.beatIdx(beatIdx),
		.act(actOdd),
		.laneSum(laneSum1)
	);

	nodeCombine #(
		.BIAS(`NEURON_BIAS)
	) joinStage (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.accEn(accEn),
		.first(first),
		.beatIdx(beatIdx),
		.laneSum0(laneSum0),
		.laneSum1(laneSum1),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

endmodule

/* sim/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
	parameter real PERIOD = 4.0,
	parameter int RESET_CYCLES = 8
)(
	output logic clk,
	output logic arstN
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Reset released a little after an edge.
	initial
	begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arstN = 1'b1;
	end

endmodule

/* sim/neuronNodeTb.sv */
`timescale 1ns/10ps
`include "neuron_defs.svh"

module neuronNodeTb;

	localparam int WORDS = `NEURON_INPUTS;

	logic clk;
	logic arstN;
	logic inValid;
	logic inReady;
	logic [31:0] actEven;
	logic [31:0] actOdd;
	logic outValid;
	logic outReady;
	logic [31:0] outData;

	logic [31:0] actWords[$];
	logic [31:0] expWords[$];
	logic [31:0] expQ[$];
	int lastBeatQ[$];
	int patCount;
	int total;
	int received;
	int cycle;
	int beatSeen;
	int vecSeen;
	int stallLeft;
	bit strict;
	bit stalling;
	bit loaded;
	logic [31:0] expNow;
	int lastNow;

	clockGen #(.PERIOD(4.0), .RESET_CYCLES(8)) clkGen (
		.clk(clk),
		.arstN(arstN)
	);

	neuronNode dut (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.actEven(actEven),
		.actOdd(actOdd),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	task automatic reportFailure();
		$display("Test failures found");
		$fatal(1, "Simulation stopped on first failure.");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			reportFailure();
		end
	endtask

	// Lines starting with # are comments; words are 8 hex digits, one space apart.
	task automatic loadPatterns();
		int fd;
		int r;
		string line;
		logic [31:0] w;
		fd = $fopen("sim/neuron_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file sim/neuron_patterns.txt.");
			reportFailure();
		end
		patCount = 0;
		while ($fgets(line, fd))
		begin
			if (line.len() >= 9 * (WORDS + 1) - 1 && line.substr(0, 0) != "#")
			begin
				for (int i = 0; i <= WORDS; i++)
				begin
					r = $sscanf(line.substr(9 * i, 9 * i + 7), "%h", w);
					if (r != 1)
					begin
						$display("A word in the pattern file could not be read as hex.");
						reportFailure();
					end
					if (i < WORDS)
						actWords.push_back(w);
					else
						expWords.push_back(w);
				end
				patCount++;
			end
		end
		$fclose(fd);
		if (patCount == 0)
		begin
			$display("The pattern file holds no vectors.");
			reportFailure();
		end
	endtask

	task automatic sendVector(input int v, input bit gaps);
		for (int b = 0; b < `NEURON_BEATS; b++)
		begin
			if (gaps)
			begin
				while ($urandom % 4 == 0)
				begin
					inValid = 1'b0;
					@(posedge clk);
					#1;
				end
			end
			inValid = 1'b1;
			actEven = actWords[v * WORDS + 2 * b];
			actOdd = actWords[v * WORDS + 2 * b + 1];
			@(negedge clk);
			while (!inReady)
				@(negedge clk);
			@(posedge clk);
			#1;
		end
	endtask

	task automatic waitResults(input int n);
		while (received < n)
			@(posedge clk);
		#1;
	endtask

	always @(posedge clk)
		cycle++;

	// Stalls can outlast a whole vector, so the input backs up.
	always @(posedge clk)
	begin
		#1;
		if (!stalling)
			outReady = 1'b1;
		else if (stallLeft > 0)
		begin
			outReady = 1'b0;
			stallLeft--;
		end
		else if ($urandom % 4 == 0)
		begin
			outReady = 1'b0;
			stallLeft = $urandom % 48;
		end
		else
			outReady = 1'b1;
	end

	// Handshakes are judged mid-cycle, where all inputs and outputs are settled.
	always @(negedge clk)
	begin
		if (arstN)
		begin
			if (!inReady)
				checkValue("outValid while inReady low", {31'd0, outValid}, 32'd1);
			if (inValid && inReady)
			begin
				if (beatSeen == `NEURON_BEATS - 1)
				begin
					expQ.push_back(expWords[vecSeen % patCount]);
					lastBeatQ.push_back(cycle + 1);
					vecSeen++;
					beatSeen = 0;
				end
				else
					beatSeen++;
			end
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					$display("An output was handed out with no vector outstanding.");
					reportFailure();
				end
				expNow = expQ.pop_front();
				lastNow = lastBeatQ.pop_front();
				checkValue("outData", outData, expNow);
				if (strict)
					checkValue("outValid latency", 32'(cycle - lastNow), 32'd2);
				received++;
			end
		end
	end

	initial
	begin
		void'($urandom(32'hdf99));
		inValid = 1'b0;
		actEven = '0;
		actOdd = '0;
		outReady = 1'b1;
		strict = 1'b1;
		stalling = 1'b0;
		stallLeft = 0;
		received = 0;
		cycle = 0;
		beatSeen = 0;
		vecSeen = 0;
		loadPatterns();
		total = 2 * patCount;
		loaded = 1'b1;
		@(posedge arstN);
		@(negedge clk);
		checkValue("outValid after reset", {31'd0, outValid}, 32'd0);
		checkValue("inReady after reset", {31'd0, inReady}, 32'd1);
		@(posedge clk);
		#1;
		// Back to back with no stalls, latency checked.
		for (int v = 0; v < patCount; v++)
			sendVector(v, 1'b0);
		inValid = 1'b0;
		waitResults(patCount);
		// Random input gaps and output stalls.
		strict = 1'b0;
		stalling = 1'b1;
		for (int v = 0; v < patCount; v++)
			sendVector(v, 1'b1);
		inValid = 1'b0;
		waitResults(total);
		stalling = 1'b0;
		repeat (4) @(posedge clk);
		if (received != total || expQ.size() != 0)
		begin
			$display("Result count is %0d, expected %0d.", received, total);
			reportFailure();
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

	initial
	begin
		int limit;
		wait (loaded);
		limit = total * `NEURON_BEATS * 8 + 8;
		repeat (limit) @(posedge clk);
		$display("The run timed out after %0d cycles without seeing every result.", limit);
		reportFailure();
	end

endmodule

/* neuronNode.f */
+incdir+hw
hw/fpPkg.sv
hw/neuronPkg.sv
hw/fpMul.sv
hw/fpAdd.sv
hw/macLane.sv
hw/nodeCombine.sv
hw/neuronNode.sv
sim/clockGen.sv
sim/neuronNodeTb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the neuronNode testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module neuronNodeTb -f neuronNode.f -o neuronSim \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
# The simulator exits non-zero on $fatal, so the log decides the result.
./obj_dir/neuronSim > sim.log 2>&1 || true
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* sim/neuron_patterns.txt */
# Columns: activations 0..29 as float32 hex, then the expected neuron output.
# Words are 8 hex digits separated by a single space.
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3EC0B9A7
4B800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4AD4EB94
4B800000 CB800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4AE60250
CB800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 CC000000 00000000 4A830EDC
00000000 CB800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4908B5E7
00000000 4B800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3EC0B9A7
